//--- design/bridge_pkg.sv
package bridge_pkg;

  // --------------------
  // Host side widths
  // --------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;  // One enable per byte lane

  // Heartbeat counter, kept short so the LED moves in simulation
  localparam int HEARTBEAT_BITS = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

  typedef enum logic {
    HOST_RD = 1'b0,
    HOST_WR = 1'b1
  } host_op_e;

  // Request as the host presents it
  // be is in host order, bit 3 selects byte 0
  typedef struct packed {
    host_op_e op;
    addr_t    addr;
    be_t      be;
    data_t    wdata;
  } host_req_t;

  // Same request after reversal, strobes in bus order
  typedef struct packed {
    host_op_e op;
    addr_t    addr;
    be_t      strb;   // Bit 0 selects byte 0
    data_t    wdata;
  } bus_req_t;

endpackage

//--- design/axil_pkg.sv
package axil_pkg;

  // --------------------
  // Block memory size
  // --------------------
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = $clog2(MEM_WORDS);  // Word index bits

  // Only the two responses this slave gives
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // --------------------
  // Channel payloads
  // --------------------
  typedef struct packed {
    bridge_pkg::addr_t addr;
  } axil_aw_t;

  typedef struct packed {
    bridge_pkg::data_t data;
    bridge_pkg::be_t   strb;   // Bus order
  } axil_w_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    bridge_pkg::addr_t addr;
  } axil_ar_t;

  typedef struct packed {
    bridge_pkg::data_t data;
    axil_resp_e        resp;
  } axil_r_t;

endpackage

//--- design/host_req_port.sv
`timescale 1ns/10ps

module host_req_port (
  input  logic                  user_clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  bridge_pkg::host_req_t host_req,
  input  logic                  link_up,
  output logic                  ack,
  output bridge_pkg::data_t     rdata,
  output logic                  err,
  output logic                  start,
  output bridge_pkg::bus_req_t  bus_req,
  input  logic                  done,
  input  bridge_pkg::data_t     bus_rdata,
  input  logic                  bus_err
);

  import bridge_pkg::*;

  typedef enum logic [1:0] {
    IDLE,   // Waiting for req with link up
    BUSY,   // Access out on the bus
    ACKED   // Result shown, waiting for req to drop
  } state_e;

  state_e state;
  be_t    strb_rev;
  logic   accept;

  // Held req is only taken once the link is up
  assign accept = (state == IDLE) && req && link_up;

  // Host byte order is mirrored against the bus
  always_comb begin
    for (int i = 0; i < BE_W; i++) begin
      strb_rev[i] = host_req.be[BE_W-1-i];
    end
  end

  // --------------------
  // Handshake FSM
  // --------------------
  always_ff @(posedge user_clk) begin
    if (!rst_n) begin
      state <= IDLE;
      start <= 1'b0;
      ack   <= 1'b0;
    end else begin
      start <= 1'b0;  // Single-cycle pulse
      case (state)
        IDLE: begin
          if (accept) begin
            start <= 1'b1;
            state <= BUSY;
          end
        end
        BUSY: begin
          if (done) begin
            ack   <= 1'b1;
            state <= ACKED;
          end
        end
        ACKED: begin
          if (!req) begin  // Four-phase return to zero
            ack   <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request capture and result latch
  always_ff @(posedge user_clk) begin
    if (accept) begin
      bus_req <= '{op: host_req.op, addr: host_req.addr, strb: strb_rev,
                   wdata: host_req.wdata};
    end
    if (state == BUSY && done) begin
      rdata <= bus_rdata;  // Stays put while ack is high
      err   <= bus_err;
    end
  end

endmodule

//--- design/axil_master.sv
`timescale 1ns/10ps

module axil_master (
  input  logic                 user_clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  bridge_pkg::bus_req_t bus_req,
  output logic                 done,
  output bridge_pkg::data_t    rdata,
  output logic                 err,
  output logic                 awvalid,
  input  logic                 awready,
  output axil_pkg::axil_aw_t   aw,
  output logic                 wvalid,
  input  logic                 wready,
  output axil_pkg::axil_w_t    w,
  input  logic                 bvalid,
  output logic                 bready,
  input  axil_pkg::axil_b_t    b,
  output logic                 arvalid,
  input  logic                 arready,
  output axil_pkg::axil_ar_t   ar,
  input  logic                 rvalid,
  output logic                 rready,
  input  axil_pkg::axil_r_t    r
);

  import bridge_pkg::*;
  import axil_pkg::*;

  typedef enum logic [2:0] {IDLE, WR_ADDR, WR_RESP, RD_ADDR, RD_DATA} state_e;

  state_e state;
  logic   aw_taken;
  logic   w_taken;

  // AW and W may be accepted on different cycles
  assign aw_taken = !awvalid || awready;
  assign w_taken  = !wvalid || wready;

  // --------------------
  // Channel control
  // --------------------
  always_ff @(posedge user_clk) begin
    if (!rst_n) begin
      state   <= IDLE;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start && bus_req.op == HOST_WR) begin
            awvalid <= 1'b1;  // Address and data go out together
            wvalid  <= 1'b1;
            state   <= WR_ADDR;
          end else if (start) begin
            arvalid <= 1'b1;
            state   <= RD_ADDR;
          end
        end
        WR_ADDR: begin
          if (awready) awvalid <= 1'b0;
          if (wready) wvalid <= 1'b0;
          if (aw_taken && w_taken) begin
            bready <= 1'b1;
            state  <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (bvalid) begin
            bready <= 1'b0;
            done   <= 1'b1;
            state  <= IDLE;
          end
        end
        RD_ADDR: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (rvalid) begin
            rready <= 1'b0;
            done   <= 1'b1;
            state  <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Channel payloads and collected response
  always_ff @(posedge user_clk) begin
    if (state == IDLE && start) begin
      aw <= '{addr: bus_req.addr};
      w  <= '{data: bus_req.wdata, strb: bus_req.strb};
      ar <= '{addr: bus_req.addr};
    end
    if (bvalid && bready) begin
      rdata <= '0;  // Nothing to return on a write
      err   <= (b.resp == RESP_SLVERR);
    end else if (rvalid && rready) begin
      rdata <= r.data;
      err   <= (r.resp == RESP_SLVERR);
    end
  end

endmodule

//--- design/axil_block_mem.sv
`timescale 1ns/10ps

module axil_block_mem (
  input  logic               user_clk,
  input  logic               rst_n,
  input  logic               awvalid,
  output logic               awready,
  input  axil_pkg::axil_aw_t aw,
  input  logic               wvalid,
  output logic               wready,
  input  axil_pkg::axil_w_t  w,
  output logic               bvalid,
  input  logic               bready,
  output axil_pkg::axil_b_t  b,
  input  logic               arvalid,
  output logic               arready,
  input  axil_pkg::axil_ar_t ar,
  output logic               rvalid,
  input  logic               rready,
  output axil_pkg::axil_r_t  r
);

  import bridge_pkg::*;
  import axil_pkg::*;

  data_t             mem [MEM_WORDS];
  logic              wr_fire, rd_fire;
  logic [MEM_AW-1:0] wr_idx, rd_idx;
  logic              wr_oor, rd_oor;

  assign wr_fire = awvalid && awready && wvalid && wready;
  assign rd_fire = arvalid && arready;
  assign wr_idx  = aw.addr[MEM_AW+1:2];            // Word address
  assign rd_idx  = ar.addr[MEM_AW+1:2];
  assign wr_oor  = |aw.addr[ADDR_W-1:MEM_AW+2];    // 1024 and up
  assign rd_oor  = |ar.addr[ADDR_W-1:MEM_AW+2];

  // --------------------
  // Handshakes
  // --------------------
  always_ff @(posedge user_clk) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      // One-cycle ready, none while a response is pending
      awready <= awvalid && wvalid && !awready && !bvalid;
      wready  <= awvalid && wvalid && !awready && !bvalid;
      arready <= arvalid && !arready && !rvalid;
      if (wr_fire) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (rd_fire) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  // Storage, cleared on reset, strobed byte writes
  always_ff @(posedge user_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) mem[i] <= '0;
    end else if (wr_fire && !wr_oor) begin
      for (int j = 0; j < BE_W; j++) begin
        if (w.strb[j]) mem[wr_idx][8*j +: 8] <= w.data[8*j +: 8];
      end
    end
  end

  // Responses, held until taken
  always_ff @(posedge user_clk) begin
    if (wr_fire) b.resp <= wr_oor ? RESP_SLVERR : RESP_OKAY;
    if (rd_fire) begin
      r.data <= rd_oor ? '0 : mem[rd_idx];  // Zero on a bad address
      r.resp <= rd_oor ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

//--- design/status_leds.sv
`timescale 1ns/10ps

module status_leds (
  input  logic user_clk,
  input  logic rst_n,
  input  logic link_up,
  output logic rst_led,
  output logic link_led,
  output logic heartbeat_led
);

  import bridge_pkg::*;

  logic [HEARTBEAT_BITS-1:0] beat_cnt;

  // --------------------
  // LED registers
  // --------------------
  always_ff @(posedge user_clk) begin
    if (!rst_n) begin
      rst_led  <= 1'b1;  // Shows reset held
      link_led <= 1'b0;
      beat_cnt <= '0;
    end else begin
      rst_led  <= 1'b0;
      link_led <= link_up;
      beat_cnt <= beat_cnt + 1'b1;  // Free running
    end
  end

  // Top bit toggles every half wrap
  assign heartbeat_led = beat_cnt[HEARTBEAT_BITS-1];

endmodule

//--- design/pcie_mem_bridge_top.sv
`timescale 1ns/10ps

module pcie_mem_bridge_top (
  input  logic                  user_clk,
  input  logic                  rst_n,
  input  logic                  link_up,
  input  logic                  req,
  input  bridge_pkg::host_req_t host_req,
  output logic                  ack,
  output bridge_pkg::data_t     rdata,
  output logic                  err,
  output logic                  rst_led,
  output logic                  link_led,
  output logic                  heartbeat_led
);

  import bridge_pkg::*;
  import axil_pkg::*;

  // Port to master
  logic     start, done, bus_err;
  bus_req_t bus_req;
  data_t    bus_rdata;

  // --------------------
  // AXI-lite channels
  // --------------------
  logic     awvalid, awready, wvalid, wready, bvalid, bready;
  logic     arvalid, arready, rvalid, rready;
  axil_aw_t aw;
  axil_w_t  w;
  axil_b_t  b;
  axil_ar_t ar;
  axil_r_t  r;

  host_req_port u_host_req_port (
    .user_clk (user_clk), .rst_n (rst_n), .req (req), .host_req (host_req),
    .link_up (link_up), .ack (ack), .rdata (rdata), .err (err),
    .start (start), .bus_req (bus_req), .done (done), .bus_rdata (bus_rdata),
    .bus_err (bus_err)
  );

  axil_master u_axil_master (
    .user_clk (user_clk), .rst_n (rst_n), .start (start), .bus_req (bus_req),
    .done (done), .rdata (bus_rdata), .err (bus_err),
    .awvalid (awvalid), .awready (awready), .aw (aw),
    .wvalid (wvalid), .wready (wready), .w (w),
    .bvalid (bvalid), .bready (bready), .b (b),
    .arvalid (arvalid), .arready (arready), .ar (ar),
    .rvalid (rvalid), .rready (rready), .r (r)
  );

  axil_block_mem u_axil_block_mem (
    .user_clk (user_clk), .rst_n (rst_n),
    .awvalid (awvalid), .awready (awready), .aw (aw),
    .wvalid (wvalid), .wready (wready), .w (w),
    .bvalid (bvalid), .bready (bready), .b (b),
    .arvalid (arvalid), .arready (arready), .ar (ar),
    .rvalid (rvalid), .rready (rready), .r (r)
  );

  // Debug LEDs beside the data path
  status_leds u_status_leds (
    .user_clk (user_clk), .rst_n (rst_n), .link_up (link_up),
    .rst_led (rst_led), .link_led (link_led), .heartbeat_led (heartbeat_led)
  );

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic user_clk
);

  localparam realtime HALF_PERIOD = 2.0;  // 4 ns period

  initial begin
    user_clk = 1'b0;
    forever #(HALF_PERIOD) user_clk = ~user_clk;
  end

endmodule

//--- tests/pcie_mem_bridge_chk.sv
`timescale 1ns/10ps

module pcie_mem_bridge_chk (
  input logic                  user_clk,
  input logic                  rst_n,
  input logic                  req,
  input bridge_pkg::host_req_t host_req,
  input logic                  ack,
  input logic                  awvalid,
  input logic                  awready,
  input logic                  bvalid,
  input logic                  bready
);

  // --------------------
  // Host handshake
  // --------------------
  ack_with_req: assert property (
    @(posedge user_clk) disable iff (!rst_n) $rose(ack) |-> req
  ) else $error("ack rose while req was low");

  // Request fields frozen for as long as req stays up
  req_stable: assert property (
    @(posedge user_clk) disable iff (!rst_n) req |=> (!req || $stable(host_req))
  ) else $error("host_req changed while req was high");

  // --------------------
  // AXI-lite channels
  // --------------------
  aw_held: assert property (
    @(posedge user_clk) disable iff (!rst_n) (awvalid && !awready) |=> awvalid
  ) else $error("awvalid dropped before awready");

  b_held: assert property (
    @(posedge user_clk) disable iff (!rst_n) (bvalid && !bready) |=> bvalid
  ) else $error("bvalid dropped before bready");

endmodule

//--- tests/pcie_mem_bridge_tb.sv
`timescale 1ns/10ps

module pcie_mem_bridge_tb;

  import bridge_pkg::*;
  import axil_pkg::*;

  localparam int ACK_TIMEOUT = 100;  // Cycles for ack to rise or fall
  localparam int LED_TIMEOUT = 300;  // Over one heartbeat half period
  localparam int HALF_BEAT   = 128;  // Top bit of an 8-bit counter
  localparam int N_PAIRS     = 40;
  localparam int N_MIXED     = 200;

  logic      user_clk;
  logic      rst_n;
  logic      link_up;
  logic      req;
  host_req_t host_req;
  logic      ack;
  data_t     rdata;
  logic      err;
  logic      rst_led;
  logic      link_led;
  logic      heartbeat_led;

  int    seed = 32'h0499e601;
  data_t ref_mem [MEM_WORDS];  // Expected memory contents
  int    check_cnt;
  int    error_cnt;
  int    tests_passed;
  int    tests_failed;

  tb_clk_gen u_tb_clk_gen (.user_clk (user_clk));

  pcie_mem_bridge_top u_pcie_mem_bridge_top (
    .user_clk (user_clk), .rst_n (rst_n), .link_up (link_up), .req (req),
    .host_req (host_req), .ack (ack), .rdata (rdata), .err (err),
    .rst_led (rst_led), .link_led (link_led), .heartbeat_led (heartbeat_led)
  );

  bind pcie_mem_bridge_top pcie_mem_bridge_chk u_pcie_mem_bridge_chk (
    .user_clk (user_clk), .rst_n (rst_n), .req (req), .host_req (host_req),
    .ack (ack), .awvalid (awvalid), .awready (awready),
    .bvalid (bvalid), .bready (bready)
  );

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  // Host bit 3 enables byte 0, host bit 0 enables byte 3
  function automatic data_t merge_host_bytes(data_t old, data_t wdata, be_t be);
    data_t res;
    res = old;
    for (int i = 0; i < BE_W; i++) begin
      if (be[BE_W-1-i]) res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

  task automatic model_access(host_op_e op, addr_t addr, be_t be, data_t wdata,
                              output data_t exp_data, output logic exp_err);
    exp_data = '0;
    exp_err  = 1'b0;
    if (addr >= 32'd1024) begin
      exp_err = 1'b1;  // Slave error, zero data, no update
    end else if (op == HOST_WR) begin
      ref_mem[addr[9:2]] = merge_host_bytes(ref_mem[addr[9:2]], wdata, be);
    end else begin
      exp_data = ref_mem[addr[9:2]];
    end
  endtask

  // --------------------
  // Compare and report
  // --------------------
  task automatic check_data(string name, data_t exp, data_t act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_err(string name, logic exp, logic act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_led(string name, logic exp, logic act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic report_failure(string what);
    error_cnt++;
    $display("ERROR %s", what);
  endtask

  task automatic finish_test(string name, int errs_before);
    if (error_cnt == errs_before) begin
      tests_passed++;
      $display("test %s: PASS", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", name, error_cnt - errs_before);
    end
  endtask

  // --------------------
  // Host side driving
  // --------------------
  task automatic wait_cycles(int n);
    repeat (n) @(posedge user_clk);
  endtask

  task automatic raise_req(host_op_e op, addr_t addr, be_t be, data_t wdata);
    @(posedge user_clk);
    req      <= 1'b1;
    host_req <= '{op: op, addr: addr, be: be, wdata: wdata};
  endtask

  task automatic wait_for_ack(output logic got);
    int n;
    got = 1'b0;
    n   = 0;
    while (!got && n < ACK_TIMEOUT) begin
      @(negedge user_clk);
      got = ack;
      n++;
    end
    if (!got) report_failure("no ack from the bridge within the timeout");
  endtask

  // Four-phase return, ack should follow req down
  task automatic drop_req();
    int n;
    n = 0;
    @(posedge user_clk);
    req <= 1'b0;
    @(negedge user_clk);
    while (ack && n < ACK_TIMEOUT) begin
      @(negedge user_clk);
      n++;
    end
    if (ack) report_failure("ack stayed high after req was dropped");
  endtask

  task automatic host_access(host_op_e op, addr_t addr, be_t be, data_t wdata,
                             output data_t rd, output logic e);
    logic got;
    raise_req(op, addr, be, wdata);
    wait_for_ack(got);
    rd = rdata;  // Valid while ack is high
    e  = err;
    drop_req();
  endtask

  task automatic run_and_check(string name, host_op_e op, addr_t addr, be_t be,
                               data_t wdata);
    data_t rd;
    data_t exp_data;
    logic  e;
    logic  exp_err;
    host_access(op, addr, be, wdata, rd, e);
    model_access(op, addr, be, wdata, exp_data, exp_err);
    check_err(name, exp_err, e);
    if (op == HOST_RD || exp_err) check_data(name, exp_data, rd);
  endtask

  task automatic wait_heartbeat_toggle(output int cycles);
    logic prev;
    prev   = heartbeat_led;
    cycles = 0;
    do begin
      @(negedge user_clk);
      cycles++;
    end while (heartbeat_led === prev && cycles < LED_TIMEOUT);
    if (heartbeat_led === prev) report_failure("heartbeat LED did not toggle in time");
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin : main_seq
    logic        got;
    logic        early;
    logic        oor;
    logic        e;
    logic        exp_e;
    int          errs;
    int          n;
    int          cycles;
    addr_t       addr;
    be_t         be;
    data_t       wdata;
    data_t       rd;
    data_t       exp_d;
    host_op_e    op;
    logic [31:0] rnd;

    rst_n    = 1'b0;
    link_up  = 1'b0;
    req      = 1'b0;
    host_req = '0;
    for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = '0;  // Cleared by reset
    check_cnt    = 0;
    error_cnt    = 0;
    tests_passed = 0;
    tests_failed = 0;

    // 1: reset and link LEDs
    errs = error_cnt;
    repeat (15) @(posedge user_clk);
    @(negedge user_clk);
    check_led("reset_rst_led", 1'b1, rst_led);
    check_led("reset_link_led", 1'b0, link_led);
    @(posedge user_clk);
    rst_n <= 1'b1;  // 16th edge ends reset
    wait_cycles(4);
    @(negedge user_clk);
    check_led("run_rst_led", 1'b0, rst_led);
    check_led("link_down_led", 1'b0, link_led);
    @(posedge user_clk);
    link_up <= 1'b1;
    got = 1'b0;
    n   = 0;
    while (!got && n < 20) begin
      @(negedge user_clk);
      got = link_led;
      n++;
    end
    if (!got) report_failure("link LED did not turn on after link up");
    finish_test("reset_and_link", errs);

    // 2: write then read back, byte order
    errs = error_cnt;
    run_and_check("be_order_wr", HOST_WR, 32'h0000_0010, 4'b1000, 32'hA1B2_C3D4);
    host_access(HOST_RD, 32'h0000_0010, 4'b0000, '0, rd, e);
    check_data("be_order_rd", 32'h0000_00D4, rd);  // Only byte 0 lands
    check_err("be_order_err", 1'b0, e);
    for (int i = 0; i < N_PAIRS; i++) begin
      rnd   = next_random();
      addr  = {22'd0, rnd[9:0]};
      rnd   = next_random();
      be    = rnd[3:0];
      wdata = next_random();
      run_and_check($sformatf("pair_wr_%0d", i), HOST_WR, addr, be, wdata);
      run_and_check($sformatf("pair_rd_%0d", i), HOST_RD, addr, 4'b0000, '0);
    end
    finish_test("write_read_pairs", errs);

    // 3: mixed traffic, about one in eight out of range
    errs = error_cnt;
    for (int i = 0; i < N_MIXED; i++) begin
      rnd   = next_random();
      op    = rnd[0] ? HOST_WR : HOST_RD;
      oor   = (rnd[3:1] == 3'd0);
      rnd   = next_random();
      addr  = oor ? (rnd | 32'h0000_0400) : {22'd0, rnd[9:0]};
      rnd   = next_random();
      be    = rnd[3:0];
      wdata = next_random();
      run_and_check($sformatf("mixed_%0d", i), op, addr, be, wdata);
      if (oor && op == HOST_WR) begin  // Aliased word must be untouched
        run_and_check($sformatf("mixed_alias_%0d", i), HOST_RD, {22'd0, addr[9:0]},
                      4'b0000, '0);
      end
    end
    finish_test("mixed_random", errs);

    // 4: req held off while the link is down
    errs = error_cnt;
    @(posedge user_clk);
    link_up <= 1'b0;
    wait_cycles(4);
    rnd   = next_random();
    addr  = {22'd0, rnd[9:2], 2'b00};
    wdata = next_random();
    raise_req(HOST_WR, addr, 4'b1111, wdata);
    early = 1'b0;
    repeat (50) begin
      @(negedge user_clk);
      if (ack) early = 1'b1;
    end
    if (early) report_failure("ack came while the link was down");
    @(posedge user_clk);
    link_up <= 1'b1;
    wait_for_ack(got);
    e = err;
    drop_req();
    model_access(HOST_WR, addr, 4'b1111, wdata, exp_d, exp_e);
    check_err("gated_wr_err", exp_e, e);
    run_and_check("gated_rd", HOST_RD, addr, 4'b0000, '0);
    finish_test("link_gating", errs);

    // 5: heartbeat half period
    errs = error_cnt;
    @(negedge user_clk);
    wait_heartbeat_toggle(cycles);  // Align to an edge
    for (int k = 0; k < 2; k++) begin
      wait_heartbeat_toggle(cycles);
      check_data("heartbeat_period", data_t'(HALF_BEAT), data_t'(cycles));
    end
    finish_test("heartbeat", errs);

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- list.f
design/bridge_pkg.sv
design/axil_pkg.sv
design/host_req_port.sv
design/axil_master.sv
design/axil_block_mem.sv
design/status_leds.sv
design/pcie_mem_bridge_top.sv
tests/tb_clk_gen.sv
tests/pcie_mem_bridge_chk.sv
tests/pcie_mem_bridge_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module pcie_mem_bridge_tb -f list.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Testbench passed" sim.log; then
  exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1
